//--- hdl/fw_pkg.sv
package fw_pkg;

   // ********************
   // Sizes
   // ********************
   localparam int NUM_WIN          = 16;
   localparam int CAUGHT_W         = 20;
   localparam int CAUGHT_VALID_BIT = 19;
   localparam int CAUGHT_OVF_BIT   = 18;

   // ********************
   // Register map
   // ********************
   localparam logic [6:0] REG_ENABLE    = 7'h00;
   localparam logic [6:0] REG_RD_CAUGHT = 7'h04;
   localparam logic [6:0] REG_WR_CAUGHT = 7'h08;
   localparam logic [6:0] REG_WIN0      = 7'h0c; // Window n at REG_WIN0 + 4n.

   // One address window. An inverted window (top below base) matches nothing.
   typedef union packed {
      logic [31:0] raw;
      struct packed {
         logic [15:0] top_page;
         logic [15:0] base_page;
      } fields;
   } window_u;

endpackage

//--- hdl/fw_window_match.sv
`timescale 1ns/10ps

module fw_window_match (
   input  logic [15:0]                   page,
   input  logic [fw_pkg::NUM_WIN*32-1:0] windows,
   output logic                          hit
);
   import fw_pkg::*;

   window_u              win [NUM_WIN];
   logic [NUM_WIN-1:0]   win_hit;

   // ********************
   // Per-window compare
   // ********************
   for (genvar i = 0; i < NUM_WIN; i++) begin : g_win
      assign win[i].raw = windows[i*32 +: 32];

      // Inclusive range. Inverted bounds never hit.
      assign win_hit[i] = (page >= win[i].fields.base_page) &&
                          (page <= win[i].fields.top_page);
   end

   assign hit = |win_hit;

endmodule

//--- hdl/fw_channel_gate.sv
`timescale 1ns/10ps

module fw_channel_gate (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          enable,
   input  logic [fw_pkg::NUM_WIN*32-1:0] windows,
   input  logic                          m_valid,
   input  logic [31:0]                   m_addr,
   input  logic                          s_ready,
   output logic                          m_ready,
   output logic                          s_valid,
   output logic [31:0]                   s_addr,
   input  logic                          clear,
   output logic [fw_pkg::CAUGHT_W-1:0]   caught
);
   import fw_pkg::*;

   logic [15:0] page;
   logic        hit;
   logic        block;
   logic        drop;

   assign page = m_addr[31:16];

   fw_window_match u_match (
      .page    (page),
      .windows (windows),
      .hit     (hit)
   );

   // ********************
   // Channel steering
   // ********************
   assign block = enable && !hit;

   // Blocked requests are accepted at once and never reach the slave.
   assign s_valid = m_valid && !block;
   assign s_addr  = m_addr;
   assign m_ready = block ? m_valid : s_ready;

   assign drop = m_valid && block; // Handshake of a dropped request.

   // ********************
   // Caught record
   // ********************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         caught <= '0;
      end else if (drop) begin
         if (clear || !caught[CAUGHT_VALID_BIT]) begin
            // New block wins over a clear in the same cycle.
            caught                   <= '0;
            caught[CAUGHT_VALID_BIT] <= 1'b1;
            caught[15:0]             <= page;
         end else begin
            caught[CAUGHT_OVF_BIT] <= 1'b1; // First page kept.
         end
      end else if (clear) begin
         caught <= '0;
      end
   end

endmodule

//--- hdl/axi_firewall_rgf.sv
`timescale 1ns/10ps

module axi_firewall_rgf (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [1:0]                    psize,
   input  logic [6:0]                    paddr,
   input  logic [31:0]                   pwdata,
   output logic [31:0]                   prdata,
   output logic                          pslverr,
   output logic                          enable,
   output logic [fw_pkg::NUM_WIN*32-1:0] windows,
   input  logic [fw_pkg::CAUGHT_W-1:0]   rd_caught_data,
   input  logic [fw_pkg::CAUGHT_W-1:0]   wr_caught_data,
   output logic                          rd_caught_data_pulse,
   output logic                          wr_caught_data_pulse
);
   import fw_pkg::*;

   logic [6:0]  word_addr;
   logic        setup;
   logic        access;
   logic        wr_pend;
   logic [6:0]  waddr;
   logic [1:0]  wsize;
   logic        rd_cap_pend;
   logic        wr_cap_pend;
   logic        wr_stb;
   logic [31:0] wmask;
   logic [31:0] wdata;
   logic [31:0] rdata_mux;

   assign word_addr = paddr & 7'h7c;
   assign setup     = psel && !penable;
   assign access    = psel && penable;
   assign pslverr   = 1'b0;

   // ********************
   // Setup phase capture
   // ********************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_pend     <= 1'b0;
         rd_cap_pend <= 1'b0;
         wr_cap_pend <= 1'b0;
         waddr       <= 7'h00;
         wsize       <= 2'd0;
      end else begin
         wr_pend     <= setup && pwrite;
         rd_cap_pend <= setup && !pwrite && (word_addr == REG_RD_CAUGHT);
         wr_cap_pend <= setup && !pwrite && (word_addr == REG_WR_CAUGHT);
         if (setup) begin
            waddr <= word_addr;
            wsize <= psize;
         end
      end
   end

   assign wr_stb = wr_pend && access;

   // Read-clear strobes, live in the access cycle only.
   assign rd_caught_data_pulse = rd_cap_pend && access;
   assign wr_caught_data_pulse = wr_cap_pend && access;

   // Narrow writes replicate the data and touch the low lanes.
   always_comb begin
      case (wsize)
         2'd1: begin
            wmask = 32'h0000_00ff;
            wdata = {4{pwdata[7:0]}};
         end
         2'd2: begin
            wmask = 32'h0000_ffff;
            wdata = {2{pwdata[15:0]}};
         end
         default: begin
            wmask = 32'hffff_ffff;
            wdata = pwdata;
         end
      endcase
   end

   // ********************
   // Register writes
   // ********************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         enable  <= 1'b0;
         windows <= '0;
      end else if (wr_stb) begin
         if (waddr == REG_ENABLE)
            enable <= wdata[0]; // Bit 0 is in every size mask.
         for (int i = 0; i < NUM_WIN; i++) begin
            if (waddr == REG_WIN0 + 7'(4 * i))
               windows[i*32 +: 32] <= (windows[i*32 +: 32] & ~wmask) | (wdata & wmask);
         end
      end
   end

   // ********************
   // Readback
   // ********************
   always_comb begin
      rdata_mux = 32'h0;
      case (word_addr)
         REG_ENABLE:    rdata_mux = {31'h0, enable};
         REG_RD_CAUGHT: rdata_mux = {{(32 - CAUGHT_W){1'b0}}, rd_caught_data};
         REG_WR_CAUGHT: rdata_mux = {{(32 - CAUGHT_W){1'b0}}, wr_caught_data};
         default: begin
            for (int i = 0; i < NUM_WIN; i++) begin
               if (word_addr == REG_WIN0 + 7'(4 * i))
                  rdata_mux = windows[i*32 +: 32];
            end
         end
      endcase
   end

   // Sampled in setup so data is ready for the access cycle.
   always_ff @(posedge clk) begin
      if (setup)
         prdata <= rdata_mux;
   end

endmodule

//--- hdl/axi_firewall.sv
`timescale 1ns/10ps

module axi_firewall (
   input  logic        clk,
   input  logic        rst_n,
   // APB
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [1:0]  psize,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pslverr,
   // Read address channel
   input  logic        m_arvalid,
   input  logic [31:0] m_araddr,
   output logic        m_arready,
   output logic        s_arvalid,
   output logic [31:0] s_araddr,
   input  logic        s_arready,
   // Write address channel
   input  logic        m_awvalid,
   input  logic [31:0] m_awaddr,
   output logic        m_awready,
   output logic        s_awvalid,
   output logic [31:0] s_awaddr,
   input  logic        s_awready
);
   import fw_pkg::*;

   logic                    enable;
   logic [NUM_WIN*32-1:0]   windows;
   logic [CAUGHT_W-1:0]     rd_caught_data;
   logic [CAUGHT_W-1:0]     wr_caught_data;
   logic                    rd_caught_data_pulse;
   logic                    wr_caught_data_pulse;

   axi_firewall_rgf u_rgf (
      .clk                  (clk),
      .rst_n                (rst_n),
      .psel                 (psel),
      .penable              (penable),
      .pwrite               (pwrite),
      .psize                (psize),
      .paddr                (paddr),
      .pwdata               (pwdata),
      .prdata               (prdata),
      .pslverr              (pslverr),
      .enable               (enable),
      .windows              (windows),
      .rd_caught_data       (rd_caught_data),
      .wr_caught_data       (wr_caught_data),
      .rd_caught_data_pulse (rd_caught_data_pulse),
      .wr_caught_data_pulse (wr_caught_data_pulse)
   );

   // ********************
   // Channel gates
   // ********************
   fw_channel_gate u_ar_gate (
      .clk     (clk),
      .rst_n   (rst_n),
      .enable  (enable),
      .windows (windows),
      .m_valid (m_arvalid),
      .m_addr  (m_araddr),
      .s_ready (s_arready),
      .m_ready (m_arready),
      .s_valid (s_arvalid),
      .s_addr  (s_araddr),
      .clear   (rd_caught_data_pulse),
      .caught  (rd_caught_data)
   );

   fw_channel_gate u_aw_gate (
      .clk     (clk),
      .rst_n   (rst_n),
      .enable  (enable),
      .windows (windows),
      .m_valid (m_awvalid),
      .m_addr  (m_awaddr),
      .s_ready (s_awready),
      .m_ready (m_awready),
      .s_valid (s_awvalid),
      .s_addr  (s_awaddr),
      .clear   (wr_caught_data_pulse),
      .caught  (wr_caught_data)
   );

endmodule

//--- testbench/fw_chk.sv
`timescale 1ns/10ps

module fw_chk (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          enable,
   input  logic [fw_pkg::NUM_WIN*32-1:0] windows,
   input  logic                          m_valid,
   input  logic [31:0]                   m_addr,
   input  logic                          m_ready,
   input  logic                          s_valid,
   input  logic                          clear,
   input  logic [fw_pkg::CAUGHT_W-1:0]   caught
);
   import fw_pkg::*;

   logic [15:0] page;
   logic        in_window;
   logic        miss;
   int          fail_count = 0;

   assign page = m_addr[31:16];

   // Inclusive page range, top page in the upper half.
   always_comb begin
      in_window = 1'b0;
      for (int i = 0; i < NUM_WIN; i++) begin
         if (page >= windows[i*32 +: 16] && page <= windows[i*32+16 +: 16])
            in_window = 1'b1;
      end
   end

   assign miss = enable && !in_window;

   // ********************
   // Blocking rules
   // ********************
   a_no_pass_on_miss : assert property (@(posedge clk) disable iff (!rst_n)
      miss |-> !s_valid)
      else begin
         $error("s_valid high for an address outside every window");
         fail_count++;
      end

   // Blocked requests never wait.
   a_block_ready : assert property (@(posedge clk) disable iff (!rst_n)
      (miss && m_valid) |-> m_ready)
      else begin
         $error("m_ready low on a blocked request");
         fail_count++;
      end

   a_sticky_valid : assert property (@(posedge clk) disable iff (!rst_n)
      $fell(caught[CAUGHT_VALID_BIT]) |-> $past(clear))
      else begin
         $error("caught valid bit dropped without a clear");
         fail_count++;
      end

endmodule

bind fw_channel_gate fw_chk u_chk (
   .clk     (clk),
   .rst_n   (rst_n),
   .enable  (enable),
   .windows (windows),
   .m_valid (m_valid),
   .m_addr  (m_addr),
   .m_ready (m_ready),
   .s_valid (s_valid),
   .clear   (clear),
   .caught  (caught)
);

//--- testbench/tb_axi_firewall.sv
`timescale 1ns/10ps

module tb_axi_firewall;
   import fw_pkg::*;

   localparam int T1_CYCLES   = 40;
   localparam int T3_CYCLES   = 80;
   localparam int T5_CYCLES   = 80;
   localparam int APB_OPS     = 160;
   // Three cycles per APB access, traffic stretched by back-pressure.
   localparam int CYCLE_LIMIT = 10 + 3 * APB_OPS + 4 * (T1_CYCLES + T3_CYCLES + T5_CYCLES) + 200;

   logic        clk;
   logic        rst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [1:0]  psize;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pslverr;
   logic        m_arvalid;
   logic [31:0] m_araddr;
   logic        m_arready;
   logic        s_arvalid;
   logic [31:0] s_araddr;
   logic        s_arready;
   logic        m_awvalid;
   logic [31:0] m_awaddr;
   logic        m_awready;
   logic        s_awvalid;
   logic [31:0] s_awaddr;
   logic        s_awready;

   // Reference model state. Index 0 is AR, 1 is AW.
   logic                model_enable;
   logic [31:0]         model_win [NUM_WIN];
   logic [CAUGHT_W-1:0] model_caught [2];
   logic                hold_v [2];
   logic [31:0]         hold_a [2];
   logic                rdy [2];

   logic [31:0] rng;
   int          err_count       = 0;
   int          test_start_errs = 0;
   int          tests_run       = 0;
   int          tests_failed    = 0;
   int          cycle_count     = 0;
   int          assert_fails    = 0;
   int          blocks_seen;
   int          passes_seen;

   axi_firewall dut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ********************
   // Model helpers
   // ********************
   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic page_in_windows(input logic [15:0] page);
      logic found;
      found = 1'b0;
      for (int i = 0; i < NUM_WIN; i++) begin
         if (page >= model_win[i][15:0] && page <= model_win[i][31:16])
            found = 1'b1;
      end
      return found;
   endfunction

   function automatic logic [CAUGHT_W-1:0] caught_after_block(input logic [CAUGHT_W-1:0] old,
                                                             input logic [15:0] page);
      logic [CAUGHT_W-1:0] rec;
      rec = old;
      if (old[CAUGHT_VALID_BIT])
         rec[CAUGHT_OVF_BIT] = 1'b1;
      else
         rec = {1'b1, 1'b0, 2'b00, page};
      return rec;
   endfunction

   function automatic logic [31:0] apply_narrow_write(input logic [31:0] old,
                                                      input logic [31:0] data,
                                                      input logic [1:0] size);
      logic [31:0] mask;
      logic [31:0] rep;
      mask = 32'hffff_ffff;
      rep  = data;
      if (size == 2'd1) begin
         mask = 32'h0000_00ff;
         rep  = {4{data[7:0]}};
      end else if (size == 2'd2) begin
         mask = 32'h0000_ffff;
         rep  = {2{data[15:0]}};
      end
      return (old & ~mask) | (rep & mask);
   endfunction

   function automatic logic [31:0] expected_reg(input logic [6:0] addr);
      logic [31:0] v;
      v = 32'h0;
      if (addr == REG_ENABLE)
         v = {31'h0, model_enable};
      else if (addr == REG_RD_CAUGHT)
         v = 32'(model_caught[0]);
      else if (addr == REG_WR_CAUGHT)
         v = 32'(model_caught[1]);
      else if (addr >= REG_WIN0 && addr < REG_WIN0 + 7'(4 * NUM_WIN))
         v = model_win[(addr - REG_WIN0) >> 2];
      return v;
   endfunction

   function automatic logic [31:0] rand_window();
      logic [31:0] r;
      logic [15:0] base;
      logic [15:0] top;
      r    = next_rand();
      base = r[15:0];
      top  = base + {4'h0, r[27:16]};
      if (r[31:29] == 3'b000)
         return {base, top}; // Inverted, matches nothing.
      return {top, base};
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("FAIL %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
      err_count++;
   endtask

   task automatic report_problem(input string msg);
      $display("Problem: %s at %0t", msg, $time);
      err_count++;
   endtask

   // Bound checkers count their own failures.
   task automatic collect_assertion_failures();
      int total;
      total = dut.u_ar_gate.u_chk.fail_count + dut.u_aw_gate.u_chk.fail_count;
      if (total > assert_fails) begin
         $display("Bound assertions failed %0d times", total - assert_fails);
         err_count    += total - assert_fails;
         assert_fails  = total;
      end
   endtask

   task automatic end_test(input string name);
      collect_assertion_failures();
      tests_run++;
      if (err_count == test_start_errs) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         $display("test %0d %s: failed, %0d errors", tests_run, name,
                  err_count - test_start_errs);
         tests_failed++;
      end
      test_start_errs = err_count;
   endtask

   // ********************
   // APB access
   // ********************
   task automatic apb_write(input logic [6:0] addr, input logic [31:0] data,
                            input logic [1:0] size);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      psize   = size;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      psize   = 2'd0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      data = prdata;
      if (pslverr !== 1'b0)
         report_mismatch("pslverr", 32'(pslverr), 32'h0);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_reg(input logic [6:0] addr, input logic [31:0] data,
                            input logic [1:0] size);
      apb_write(addr, data, size);
      if (addr == REG_ENABLE)
         model_enable = data[0];
      else if (addr >= REG_WIN0 && addr < REG_WIN0 + 7'(4 * NUM_WIN))
         model_win[(addr - REG_WIN0) >> 2] =
            apply_narrow_write(model_win[(addr - REG_WIN0) >> 2], data, size);
   endtask

   task automatic check_reg(input logic [6:0] addr);
      logic [31:0] got;
      logic [31:0] exp;
      exp = expected_reg(addr);
      apb_read(addr, got);
      if (got !== exp)
         report_mismatch($sformatf("prdata@0x%02h", addr), got, exp);
      if (addr == REG_RD_CAUGHT)
         model_caught[0] = '0; // Read clears.
      if (addr == REG_WR_CAUGHT)
         model_caught[1] = '0;
   endtask

   task automatic check_all_regs();
      for (int a = 0; a <= 'h48; a += 4)
         check_reg(7'(a));
   endtask

   // ********************
   // AXI address traffic
   // ********************
   task automatic drive_axi();
      m_arvalid = hold_v[0];
      m_araddr  = hold_a[0];
      s_arready = rdy[0];
      m_awvalid = hold_v[1];
      m_awaddr  = hold_a[1];
      s_awready = rdy[1];
   endtask

   task automatic check_axi();
      logic        got_sv;
      logic        got_mr;
      logic [31:0] got_sa;
      logic        blk;
      logic        exp_sv;
      logic        exp_mr;
      string       nm;
      for (int ch = 0; ch < 2; ch++) begin
         nm     = (ch == 0) ? "ar" : "aw";
         got_sv = (ch == 0) ? s_arvalid : s_awvalid;
         got_mr = (ch == 0) ? m_arready : m_awready;
         got_sa = (ch == 0) ? s_araddr : s_awaddr;
         blk    = model_enable && !page_in_windows(hold_a[ch][31:16]);
         exp_sv = hold_v[ch] && !blk;
         exp_mr = blk ? hold_v[ch] : rdy[ch];
         if (got_sv !== exp_sv)
            report_mismatch({"s_", nm, "valid"}, 32'(got_sv), 32'(exp_sv));
         if (got_mr !== exp_mr)
            report_mismatch({"m_", nm, "ready"}, 32'(got_mr), 32'(exp_mr));
         if (hold_v[ch] && !blk && got_sa !== hold_a[ch])
            report_mismatch({"s_", nm, "addr"}, got_sa, hold_a[ch]);
         if (hold_v[ch] && blk) begin
            model_caught[ch] = caught_after_block(model_caught[ch], hold_a[ch][31:16]);
            blocks_seen++;
         end else if (hold_v[ch] && exp_mr) begin
            passes_seen++;
         end
         if (hold_v[ch] && exp_mr)
            hold_v[ch] = 1'b0; // Handshake done.
      end
   endtask

   // Random requests held until accepted, then drained to idle.
   task automatic run_traffic(input int cycles, input logic [7:0] ready_low);
      int          c;
      logic [31:0] r;
      c = 0;
      while (c < cycles || hold_v[0] || hold_v[1]) begin
         @(posedge clk);
         #1;
         for (int ch = 0; ch < 2; ch++) begin
            r = next_rand();
            if (!hold_v[ch] && c < cycles && r[1:0] != 2'b00) begin
               hold_v[ch] = 1'b1;
               hold_a[ch] = next_rand();
            end
            r       = next_rand();
            rdy[ch] = (r[7:0] >= ready_low);
         end
         drive_axi();
         @(negedge clk);
         check_axi();
         c++;
      end
      @(posedge clk);
      #1;
      m_arvalid = 1'b0;
      m_awvalid = 1'b0;
   endtask

   task automatic single_request(input int ch, input logic [31:0] addr);
      @(posedge clk);
      #1;
      hold_v[ch]     = 1'b1;
      hold_a[ch]     = addr;
      hold_v[1 - ch] = 1'b0;
      rdy[0]         = 1'b1;
      rdy[1]         = 1'b1;
      drive_axi();
      @(negedge clk);
      check_axi();
      @(posedge clk);
      #1;
      m_arvalid = 1'b0;
      m_awvalid = 1'b0;
   endtask

   task automatic find_miss(output logic [31:0] addr, output logic ok);
      logic [31:0] a;
      ok   = 1'b0;
      addr = 32'h0;
      for (int i = 0; i < 4096 && !ok; i++) begin
         a = next_rand();
         if (!page_in_windows(a[31:16])) begin
            ok   = 1'b1;
            addr = a;
         end
      end
   endtask

   // ********************
   // Timeout
   // ********************
   initial begin
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout after %0d cycles", cycle_count);
      $display("ERRORS FOUND");
      $finish;
   end

   // ********************
   // Test sequence
   // ********************
   initial begin
      logic [31:0] a1;
      logic [31:0] a2;
      logic        ok1;
      logic        ok2;
      logic [31:0] r;
      logic [6:0]  waddr;

      rng       = 32'd71101;
      rst_n     = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      psize     = 2'd0;
      paddr     = 7'h00;
      pwdata    = 32'h0;
      m_arvalid = 1'b0;
      m_araddr  = 32'h0;
      s_arready = 1'b0;
      m_awvalid = 1'b0;
      m_awaddr  = 32'h0;
      s_awready = 1'b0;
      model_enable = 1'b0;
      for (int i = 0; i < NUM_WIN; i++)
         model_win[i] = 32'h0;
      for (int ch = 0; ch < 2; ch++) begin
         model_caught[ch] = '0;
         hold_v[ch]       = 1'b0;
         hold_a[ch]       = 32'h0;
         rdy[ch]          = 1'b0;
      end
      blocks_seen = 0;
      passes_seen = 0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;

      check_all_regs();
      run_traffic(T1_CYCLES, 8'd64);
      end_test("reset_and_passthrough");

      for (int i = 0; i < NUM_WIN; i++)
         write_reg(REG_WIN0 + 7'(4 * i), next_rand(), 2'd0);
      write_reg(REG_ENABLE, next_rand(), 2'd0);
      check_all_regs();
      for (int i = 0; i < 8; i++) begin
         r     = next_rand();
         waddr = REG_WIN0 + 7'(4 * r[3:0]);
         write_reg(waddr, next_rand(), r[4] ? 2'd1 : 2'd2);
         check_reg(waddr);
      end
      write_reg(REG_ENABLE, next_rand(), 2'd1);
      check_reg(REG_ENABLE);
      end_test("register_access");

      for (int i = 0; i < NUM_WIN; i++)
         write_reg(REG_WIN0 + 7'(4 * i), rand_window(), 2'd0);
      write_reg(REG_ENABLE, 32'h1, 2'd0);
      check_reg(REG_RD_CAUGHT);
      check_reg(REG_WR_CAUGHT);
      blocks_seen = 0;
      passes_seen = 0;
      run_traffic(T3_CYCLES, 8'd0);
      if (blocks_seen == 0 || passes_seen == 0)
         report_problem("traffic did not mix passing and blocked requests");
      end_test("window_blocking");

      check_reg(REG_RD_CAUGHT);
      check_reg(REG_WR_CAUGHT);
      check_reg(REG_RD_CAUGHT);
      check_reg(REG_WR_CAUGHT);
      find_miss(a1, ok1);
      find_miss(a2, ok2);
      if (!ok1 || !ok2) begin
         report_problem("no address outside the windows was found");
      end else begin
         single_request(0, a1);
         check_reg(REG_RD_CAUGHT);
         single_request(1, a1);
         single_request(1, a2); // Sets overflow, keeps first page.
         check_reg(REG_WR_CAUGHT);
         check_reg(REG_WR_CAUGHT);
      end
      end_test("capture_registers");

      blocks_seen = 0;
      passes_seen = 0;
      run_traffic(T5_CYCLES, 8'd128);
      if (blocks_seen == 0 || passes_seen == 0)
         report_problem("traffic did not mix passing and blocked requests");
      check_reg(REG_RD_CAUGHT);
      check_reg(REG_WR_CAUGHT);
      end_test("back_pressure");

      $display("tests run %0d, tests failed %0d, check errors %0d",
               tests_run, tests_failed, err_count);
      if (err_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- compile.f
hdl/fw_pkg.sv
hdl/fw_window_match.sv
hdl/fw_channel_gate.sv
hdl/axi_firewall_rgf.sv
hdl/axi_firewall.sv
testbench/fw_chk.sv
testbench/tb_axi_firewall.sv
